/* hw/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

    // {ras_n, cas_n, we_n}.
    localparam logic [2:0] cmd_nop   = 3'b111;
    localparam logic [2:0] cmd_pre   = 3'b010;
    localparam logic [2:0] cmd_ref   = 3'b001;
    localparam logic [2:0] cmd_mrs   = 3'b000;
    localparam logic [2:0] cmd_act   = 3'b011;
    localparam logic [2:0] cmd_read  = 3'b101;
    localparam logic [2:0] cmd_write = 3'b100;
    localparam logic [2:0] cmd_bst   = 3'b110;

    // word address is {bank, row, column}.
    localparam int addr_w = 25;
    localparam int ba_w   = 2;
    localparam int row_w  = 13;
    localparam int col_w  = 10;
    localparam int data_w = 16;

    localparam int burst_len = 4;
    localparam int read_max  = 64;

    // timing in clock cycles.
    localparam int cas_lat          = 2;
    localparam int t_rcd            = 2;
    localparam int init_wait        = 100;
    localparam int refresh_interval = 200;

    // the device model keeps only the low address bits.
    localparam int model_addr_w = 16;
    localparam int model_depth  = 1 << model_addr_w;

    // counter widths.
    localparam int wait_w   = $clog2(init_wait);
    localparam int ref_w    = $clog2(refresh_interval);
    localparam int burst_w  = $clog2(burst_len);
    localparam int rd_cnt_w = $clog2(read_max + cas_lat);

    // cas latency 2, sequential full page, single location writes.
    localparam logic [row_w-1:0] mode_word = 13'b0_0010_0010_0111;

    // a10 high selects all banks on precharge.
    localparam logic [row_w-1:0] pre_all = 13'h0400;

endpackage

`default_nettype wire

/* hw/sdram_host_if.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_host_if (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic                                            req,
    input  logic                                            wr,
    input  logic [sdram_pkg::addr_w-1:0]                    addr,
    input  logic [sdram_pkg::data_w-1:0]                    wdata,
    output logic                                            ack,
    output logic [sdram_pkg::burst_len*sdram_pkg::data_w-1:0] rdata,
    output logic                                            start,
    output logic                                            op_wr,
    output logic [sdram_pkg::addr_w-1:0]                    op_addr,
    output logic [sdram_pkg::data_w-1:0]                    op_wdata,
    input  logic                                            rd_valid,
    input  logic                                            done,
    input  logic [sdram_pkg::data_w-1:0]                    rd_word
);

    logic busy;
    logic accept;

    // a new request only once the previous ack has been released.
    assign accept = req && !busy && !ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start <= 1'b0;
            busy  <= 1'b0;
            ack   <= 1'b0;
        end else begin
            start <= 1'b0;
            if (accept) begin
                start <= 1'b1;
                busy  <= 1'b1;
            end
            if (busy && done) begin
                busy <= 1'b0;
                ack  <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_wr    <= wr;
            op_addr  <= addr;
            op_wdata <= wdata;
        end
        // shift right so the first word lands in the low bits.
        if (rd_valid) begin
            rdata <= {rd_word, rdata[sdram_pkg::burst_len*sdram_pkg::data_w-1:sdram_pkg::data_w]};
        end
    end

endmodule

`default_nettype wire

/* hw/sdram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          start,
    input  logic                          op_wr,
    input  logic [sdram_pkg::addr_w-1:0]  op_addr,
    input  logic [sdram_pkg::data_w-1:0]  op_wdata,
    output logic                          rd_valid,
    output logic [sdram_pkg::data_w-1:0]  rd_word,
    output logic                          done,
    output logic [sdram_pkg::row_w-1:0]   sd_addr,
    output logic [sdram_pkg::ba_w-1:0]    sd_ba,
    output logic                          ras_n,
    output logic                          cas_n,
    output logic                          we_n,
    inout  wire  [sdram_pkg::data_w-1:0]  dq
);

    typedef enum logic [2:0] {
        st_init,
        st_idle,
        st_ref,
        st_act_wait,
        st_write,
        st_read_wait,
        st_read_stream,
        st_pre
    } state_t;

    state_t                          state;
    logic [sdram_pkg::wait_w-1:0]    wait_cnt;
    logic [2:0]                      init_step;
    logic [sdram_pkg::ref_w-1:0]     ref_cnt;
    logic                            ref_pend;
    logic                            op_pend;
    logic [sdram_pkg::burst_w-1:0]   word_cnt;
    logic [2:0]                      cmd_q;
    logic                            dq_oe;

    assign {ras_n, cas_n, we_n} = cmd_q;

    // write data is on the bus only with the write command.
    assign dq_oe = (cmd_q == sdram_pkg::cmd_write);
    assign dq    = dq_oe ? op_wdata : 'z;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_init;
            wait_cnt  <= sdram_pkg::wait_w'(sdram_pkg::init_wait - 1);
            init_step <= '0;
            ref_cnt   <= sdram_pkg::ref_w'(sdram_pkg::refresh_interval - 1);
            ref_pend  <= 1'b0;
            op_pend   <= 1'b0;
            word_cnt  <= '0;
            cmd_q     <= sdram_pkg::cmd_nop;
            sd_addr   <= '0;
            sd_ba     <= '0;
            rd_valid  <= 1'b0;
            done      <= 1'b0;
        end else begin
            cmd_q    <= sdram_pkg::cmd_nop;
            rd_valid <= 1'b0;
            done     <= 1'b0;

            // start is a single pulse, hold it until the row is opened.
            if (start) begin
                op_pend <= 1'b1;
            end

            case (state)
                st_init: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else begin
                        init_step <= init_step + 1'b1;
                        case (init_step)
                            3'd0: begin
                                cmd_q   <= sdram_pkg::cmd_pre;
                                sd_addr <= sdram_pkg::pre_all;
                            end
                            3'd2, 3'd4: cmd_q <= sdram_pkg::cmd_ref;
                            3'd6: begin
                                cmd_q   <= sdram_pkg::cmd_mrs;
                                sd_addr <= sdram_pkg::mode_word;
                                state   <= st_idle;
                            end
                            default: cmd_q <= sdram_pkg::cmd_nop;
                        endcase
                    end
                end
                st_idle: begin
                    // refresh goes first, an access never gets split by one.
                    if (ref_pend) begin
                        cmd_q    <= sdram_pkg::cmd_ref;
                        ref_pend <= 1'b0;
                        state    <= st_ref;
                    end else if (op_pend) begin
                        cmd_q    <= sdram_pkg::cmd_act;
                        sd_ba    <= op_addr[sdram_pkg::addr_w-1 -: sdram_pkg::ba_w];
                        sd_addr  <= op_addr[sdram_pkg::col_w +: sdram_pkg::row_w];
                        op_pend  <= 1'b0;
                        wait_cnt <= sdram_pkg::wait_w'(sdram_pkg::t_rcd - 1);
                        state    <= st_act_wait;
                    end
                end
                st_ref: begin
                    state <= st_idle;
                end
                st_act_wait: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else begin
                        // column only, so a10 stays low and no auto precharge.
                        sd_addr <= sdram_pkg::row_w'(op_addr[sdram_pkg::col_w-1:0]);
                        if (op_wr) begin
                            cmd_q <= sdram_pkg::cmd_write;
                            state <= st_write;
                        end else begin
                            cmd_q    <= sdram_pkg::cmd_read;
                            wait_cnt <= sdram_pkg::wait_w'(sdram_pkg::cas_lat - 1);
                            state    <= st_read_wait;
                        end
                    end
                end
                st_write: begin
                    cmd_q <= sdram_pkg::cmd_pre;
                    state <= st_pre;
                end
                st_read_wait: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else begin
                        word_cnt <= '0;
                        state    <= st_read_stream;
                    end
                end
                st_read_stream: begin
                    rd_valid <= 1'b1;
                    word_cnt <= word_cnt + 1'b1;
                    // stop goes out while the last word is on dq.
                    if (word_cnt == sdram_pkg::burst_w'(sdram_pkg::burst_len - 2)) begin
                        cmd_q <= sdram_pkg::cmd_bst;
                    end
                    if (word_cnt == sdram_pkg::burst_w'(sdram_pkg::burst_len - 1)) begin
                        cmd_q <= sdram_pkg::cmd_pre;
                        state <= st_pre;
                    end
                end
                st_pre: begin
                    done  <= 1'b1;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase

            // refresh timer runs once init is over.
            if (state == st_init) begin
                ref_cnt <= sdram_pkg::ref_w'(sdram_pkg::refresh_interval - 1);
            end else if (ref_cnt == '0) begin
                ref_cnt  <= sdram_pkg::ref_w'(sdram_pkg::refresh_interval - 1);
                ref_pend <= 1'b1;
            end else begin
                ref_cnt <= ref_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_read_stream) begin
            rd_word <= dq;
        end
    end

endmodule

`default_nettype wire

/* hw/sdram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  logic                         clk,
    input  logic [sdram_pkg::row_w-1:0]  addr,
    input  logic [sdram_pkg::ba_w-1:0]   ba,
    input  logic                         ras_n,
    input  logic                         cas_n,
    input  logic                         we_n,
    inout  wire  [sdram_pkg::data_w-1:0] dq
);

    typedef enum logic [1:0] {
        st_idle,
        st_active,
        st_write,
        st_read
    } state_t;

    state_t                                       state = st_idle;
    state_t                                       state_nxt;
    logic [2:0]                                   cmd;
    logic [sdram_pkg::ba_w+sdram_pkg::row_w-1:0]  bank_row;
    logic [sdram_pkg::col_w-1:0]                  col;
    logic [sdram_pkg::rd_cnt_w-1:0]               rd_cnt = '0;
    logic [sdram_pkg::rd_cnt_w-1:0]               rd_cnt_nxt;
    logic [sdram_pkg::addr_w-1:0]                 wr_addr;
    logic [sdram_pkg::addr_w-1:0]                 rd_addr;
    logic [sdram_pkg::data_w-1:0]                 mem [sdram_pkg::model_depth];
    logic                                         drive = 1'b0;
    logic [sdram_pkg::data_w-1:0]                 dq_val;

    assign cmd        = {ras_n, cas_n, we_n};
    assign rd_cnt_nxt = rd_cnt + 1'b1;
    assign wr_addr    = {bank_row, addr[sdram_pkg::col_w-1:0]};

    // word k of the burst is read at count cas_lat + k.
    assign rd_addr = {bank_row, col} + sdram_pkg::addr_w'(rd_cnt_nxt)
                   - sdram_pkg::addr_w'(sdram_pkg::cas_lat);

    assign dq = drive ? dq_val : 'z;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (cmd == sdram_pkg::cmd_act) begin
                    state_nxt = st_active;
                end
            end
            st_active: begin
                if (cmd == sdram_pkg::cmd_write) begin
                    state_nxt = st_write;
                end else if (cmd == sdram_pkg::cmd_read) begin
                    state_nxt = st_read;
                end
            end
            st_write: state_nxt = st_idle;
            st_read: begin
                // burst stop only counts once the first word is out.
                if ((rd_cnt >= sdram_pkg::cas_lat && cmd == sdram_pkg::cmd_bst) ||
                    rd_cnt == sdram_pkg::rd_cnt_w'(sdram_pkg::read_max + sdram_pkg::cas_lat - 1)) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        state <= state_nxt;
        case (state_nxt)
            st_idle: begin
                rd_cnt <= '0;
                drive  <= 1'b0;
            end
            st_active: begin
                if (cmd == sdram_pkg::cmd_act) begin
                    bank_row <= {ba, addr};
                end
            end
            st_write: begin
                mem[wr_addr[sdram_pkg::model_addr_w-1:0]] <= dq;
            end
            st_read: begin
                if (state != st_read) begin
                    col <= addr[sdram_pkg::col_w-1:0];
                end
                rd_cnt <= rd_cnt_nxt;
                if (rd_cnt_nxt >= sdram_pkg::cas_lat) begin
                    dq_val <= mem[rd_addr[sdram_pkg::model_addr_w-1:0]];
                    drive  <= 1'b1;
                end
            end
            default: drive <= 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/sdram_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  logic                                              req,
    input  logic                                              wr,
    input  logic [sdram_pkg::addr_w-1:0]                      addr,
    input  logic [sdram_pkg::data_w-1:0]                      wdata,
    output logic                                              ack,
    output logic [sdram_pkg::burst_len*sdram_pkg::data_w-1:0] rdata
);

    logic                          start;
    logic                          op_wr;
    logic [sdram_pkg::addr_w-1:0]  op_addr;
    logic [sdram_pkg::data_w-1:0]  op_wdata;
    logic                          rd_valid;
    logic [sdram_pkg::data_w-1:0]  rd_word;
    logic                          done;
    logic [sdram_pkg::row_w-1:0]   sd_addr;
    logic [sdram_pkg::ba_w-1:0]    sd_ba;
    logic                          ras_n;
    logic                          cas_n;
    logic                          we_n;

    // shared data bus between controller and device.
    wire  [sdram_pkg::data_w-1:0]  dq;

    sdram_host_if i_host (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .rdata    (rdata),
        .start    (start),
        .op_wr    (op_wr),
        .op_addr  (op_addr),
        .op_wdata (op_wdata),
        .rd_valid (rd_valid),
        .done     (done),
        .rd_word  (rd_word)
    );

    sdram_ctrl i_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .op_wr    (op_wr),
        .op_addr  (op_addr),
        .op_wdata (op_wdata),
        .rd_valid (rd_valid),
        .rd_word  (rd_word),
        .done     (done),
        .sd_addr  (sd_addr),
        .sd_ba    (sd_ba),
        .ras_n    (ras_n),
        .cas_n    (cas_n),
        .we_n     (we_n),
        .dq       (dq)
    );

    sdram_model i_mem (
        .clk   (clk),
        .addr  (sd_addr),
        .ba    (sd_ba),
        .ras_n (ras_n),
        .cas_n (cas_n),
        .we_n  (we_n),
        .dq    (dq)
    );

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    // 100 ns period.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for ten rising edges, released on a falling edge.
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/sdram_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_chk (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         ras_n,
    input  logic                         cas_n,
    input  logic                         we_n,
    input  logic                         done,
    input  logic [sdram_pkg::data_w-1:0] dq,
    input  logic [sdram_pkg::data_w-1:0] op_wdata
);

    logic [2:0] cmd;
    logic       init_done;
    int         act_age;
    int         ref_age;

    assign cmd = {ras_n, cas_n, we_n};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_done <= 1'b0;
            act_age   <= 0;
            ref_age   <= 0;
        end else begin
            if (cmd == sdram_pkg::cmd_mrs) begin
                init_done <= 1'b1;
            end
            if (cmd == sdram_pkg::cmd_act) begin
                act_age <= 1;
            end else if (act_age != 0 && act_age < sdram_pkg::t_rcd) begin
                act_age <= act_age + 1;
            end else begin
                act_age <= 0;
            end
            if (cmd == sdram_pkg::cmd_ref || cmd == sdram_pkg::cmd_mrs) begin
                ref_age <= 0;
            end else begin
                ref_age <= ref_age + 1;
            end
        end
    end

    // only NOP goes out while the row opens.
    assert property (@(posedge clk) disable iff (!arst_n)
        (act_age != 0 && act_age < sdram_pkg::t_rcd) |-> cmd == sdram_pkg::cmd_nop)
    else $error("command other than NOP while the row was opening");

    assert property (@(posedge clk) disable iff (!arst_n)
        act_age == sdram_pkg::t_rcd |->
            (cmd == sdram_pkg::cmd_read || cmd == sdram_pkg::cmd_write))
    else $error("no read or write command t_rcd cycles after activate");

    assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

    // the write word has to be on the shared bus with the write command.
    assert property (@(posedge clk) disable iff (!arst_n)
        cmd == sdram_pkg::cmd_write |-> dq == op_wdata)
    else $error("write data was not on dq with the write command");

    // 16 cycles cover the longest access that a pending refresh waits behind.
    assert property (@(posedge clk) disable iff (!arst_n)
        init_done |-> ref_age <= sdram_pkg::refresh_interval + 16)
    else $error("auto-refresh overdue");

endmodule

bind sdram_ctrl sdram_chk i_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .ras_n    (ras_n),
    .cas_n    (cas_n),
    .we_n     (we_n),
    .done     (done),
    .dq       (dq),
    .op_wdata (op_wdata)
);

`default_nettype wire

/* testbench/tb_sdram.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram;

    logic                                              clk;
    logic                                              arst_n;
    logic                                              req;
    logic                                              wr;
    logic [sdram_pkg::addr_w-1:0]                      addr;
    logic [sdram_pkg::data_w-1:0]                      wdata;
    logic                                              ack;
    logic [sdram_pkg::burst_len*sdram_pkg::data_w-1:0] rdata;

    // expected device contents, indexed like the model memory.
    logic [sdram_pkg::data_w-1:0] shadow [sdram_pkg::model_depth];
    bit                           written [sdram_pkg::model_depth];
    bit                           first_done;

    tb_clk_gen i_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    sdram_subsys i_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .wr     (wr),
        .addr   (addr),
        .wdata  (wdata),
        .ack    (ack),
        .rdata  (rdata)
    );

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // steps on falling edges until ack reaches the level.
    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        while (ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles >= 2000) begin
                fail_stop($sformatf("timeout: ack did not go to %0d within %0d cycles",
                                    level, cycles));
            end
        end
    endtask

    // one four-phase handshake, entered and left on a falling edge.
    task automatic host_access(input logic is_wr, input logic [sdram_pkg::addr_w-1:0] a,
                               input logic [sdram_pkg::data_w-1:0] d, input int hold,
                               output logic [63:0] rd);
        int cycles;
        req   = 1'b1;
        wr    = is_wr;
        addr  = a;
        wdata = d;
        wait_ack(1'b1, cycles);
        if (!first_done) begin
            assert (cycles >= sdram_pkg::init_wait)
            else fail_stop("first request was acknowledged before the init sequence ended");
            first_done = 1'b1;
        end
        rd = rdata;
        repeat (hold) begin
            @(negedge clk);
            assert (ack === 1'b1) else fail_stop("ack dropped while req was still high");
        end
        req = 1'b0;
        wait_ack(1'b0, cycles);
    endtask

    task automatic write_word(input logic [sdram_pkg::addr_w-1:0] a,
                              input logic [sdram_pkg::data_w-1:0] d);
        logic [63:0] unused;
        host_access(1'b1, a, d, 0, unused);
        shadow[a[sdram_pkg::model_addr_w-1:0]]  = d;
        written[a[sdram_pkg::model_addr_w-1:0]] = 1'b1;
    endtask

    task automatic read_check(input logic [sdram_pkg::addr_w-1:0] a,
                              input logic [63:0] exp, input int hold);
        logic [63:0] got;
        host_access(1'b0, a, '0, hold, got);
        assert (got === exp)
        else fail_stop($sformatf("Fail rdata at address %h: expected %h, got %h", a, exp, got));
    endtask

    // random accesses in a 64-word window in the upper half of the model memory.
    task automatic random_traffic(input int count);
        logic [sdram_pkg::model_addr_w-1:0] base;
        logic [sdram_pkg::model_addr_w-1:0] a;
        logic [sdram_pkg::model_addr_w-1:0] idx;
        logic [63:0]                        exp;
        bit                                 full;
        base = sdram_pkg::model_addr_w'(32'h8000 | ($urandom & 32'h7fc0));
        for (int i = 0; i < count; i++) begin
            a    = base + sdram_pkg::model_addr_w'($urandom % 64);
            full = 1'b1;
            exp  = '0;
            for (int k = 0; k < sdram_pkg::burst_len; k++) begin
                idx  = a + sdram_pkg::model_addr_w'(k);
                full = full & written[idx];
                exp  = {shadow[idx], exp[63:16]};
            end
            if (full && ($urandom % 2 == 0)) begin
                read_check(sdram_pkg::addr_w'(a), exp, 0);
            end else begin
                write_word(sdram_pkg::addr_w'(a), sdram_pkg::data_w'($urandom));
            end
        end
    endtask

    initial begin
        int          fd;
        int          waited;
        string       line;
        byte         op;
        logic [63:0] f1;
        logic [63:0] f2;
        logic [63:0] f3;

        void'($urandom(32'hc5f2_ba54));
        req        = 1'b0;
        wr         = 1'b0;
        addr       = '0;
        wdata      = '0;
        first_done = 1'b0;

        // ack stays low through reset and with no request pending.
        waited = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            waited++;
            assert (ack === 1'b0) else fail_stop("ack was not low during reset");
            if (waited >= 2000) begin
                fail_stop("timeout: reset was never released");
            end
        end
        repeat (5) begin
            @(negedge clk);
            assert (ack === 1'b0) else fail_stop("ack rose without a request");
        end

        fd = $fopen("testbench/sdram_patterns.txt", "r");
        if (fd == 0) begin
            fail_stop("could not open testbench/sdram_patterns.txt");
        end
        while ($fgets(line, fd) > 0) begin
            op = " ";
            f1 = '0;
            f2 = '0;
            f3 = '0;
            void'($sscanf(line, "%c %h %h %h", op, f1, f2, f3));
            case (op)
                "w": write_word(sdram_pkg::addr_w'(f1), sdram_pkg::data_w'(f2));
                "r": read_check(sdram_pkg::addr_w'(f1), f2, 0);
                "h": read_check(sdram_pkg::addr_w'(f1), f2, int'(f3));
                "g": repeat (int'(f1)) @(negedge clk);
                "x": random_traffic(int'(f1));
                "#", " ", "\n", "\r": ;
                default: fail_stop($sformatf("unknown operation in pattern line: %s", line));
            endcase
        end
        $fclose(fd);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/sdram_patterns.txt */
# columns: op addr data extra, all numbers in hex; first burst word in the low bits
# w addr word | r addr burst | h addr burst hold_cycles | g cycles | x random_ops
w 0000100 a1b2
w 0000101 c3d4
w 0000102 e5f6
w 0000103 0718
r 0000100 0718e5f6c3d4a1b2
w 00007fe 1357
w 00007ff 2468
w 0000800 369c
w 0000801 48ad
r 00007fe 48ad369c24681357
w 0000c00 9a01
w 0000c01 9a02
w 0000c02 9a03
w 0000c03 9a04
w 0000802 5be0
w 0000803 5be1
r 0000800 5be15be048ad369c
r 0000c00 9a049a039a029a01
g 0fa
r 0000100 0718e5f6c3d4a1b2
g 12c
h 00007fe 48ad369c24681357 0190
r 0000c00 9a049a039a029a01
g 0d2
x 0c8
r 0000100 0718e5f6c3d4a1b2
r 0000800 5be15be048ad369c

/* sources.f */
hw/sdram_pkg.sv
hw/sdram_host_if.sv
hw/sdram_ctrl.sv
hw/sdram_model.sv
hw/sdram_subsys.sv
testbench/tb_clk_gen.sv
testbench/sdram_chk.sv
testbench/tb_sdram.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the SDRAM testbench with Verilator and runs it from the project root.
set -u

if ! cd "$(dirname "$0")"; then
    echo "cannot enter the project directory"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module tb_sdram -f sources.f -o sim_tb_sdram; then
    echo "Verilator build failed"
    exit 1
fi

if [ ! -x obj_dir/sim_tb_sdram ]; then
    echo "simulation executable is missing"
    exit 1
fi

./obj_dir/sim_tb_sdram
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with exit status $status"
    exit "$status"
fi

exit 0
